//--- src/rxdp_config.svh
`ifndef RXDP_CONFIG_SVH
`define RXDP_CONFIG_SVH

// --------------------------------------------------
// Datapath widths
// --------------------------------------------------
`define RXDP_SRC_W        78   // Lane source word
`define RXDP_WORD_W       80   // FIFO word, two marker bits added
`define RXDP_HALF_W       40   // Output half word

// --------------------------------------------------
// FIFO geometry
// --------------------------------------------------
`define RXDP_FIFO_DEPTH   16
`define RXDP_FIFO_AW      4    // log2 of depth

// --------------------------------------------------
// Register block
// --------------------------------------------------
`define RXDP_CNT_W        8    // Drop counter, saturates
`define RXDP_STRETCH_W    3
`define RXDP_APB_AW       4

`endif

//--- src/rxdp_pkg.sv
`default_nettype none

`include "rxdp_config.svh"

package rxdp_pkg;

  // Datapath source select
  typedef enum logic [1:0] {
    MAP_EHIP,   // Ethernet hard IP lanes
    MAP_ELANE,
    MAP_RSFEC,
    MAP_LPBK    // Transmit FIFO loopback, already 80 bits
  } rxdp_map_mode_e;

  typedef enum logic [`RXDP_APB_AW-1:0] {
    REG_CTRL    = 'h0,
    REG_STRETCH = 'h4,
    REG_DROP    = 'h8,
    REG_LEVEL   = 'hC
  } rxdp_reg_addr_e;

  typedef enum logic [1:0] {RD_IDLE, RD_LO, RD_HI} rxdp_rd_state_e;

endpackage

`default_nettype wire

//--- src/rxdp_csr.sv
`default_nettype none
`timescale 1ns/1ps

`include "rxdp_config.svh"

module rxdp_csr
  import rxdp_pkg::*;
(
  input  logic                      rx_clock_fifo_clk,
  input  logic                      arst_n,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [`RXDP_APB_AW-1:0]   paddr,
  input  logic [31:0]               pwdata,
  input  logic                      drop,
  input  logic [`RXDP_FIFO_AW:0]    level,
  output logic [31:0]               prdata,
  output logic                      pready,
  output logic                      pslverr,
  output rxdp_map_mode_e            map_mode,
  output logic                      wm_en,
  output logic                      stop_read,
  output logic [`RXDP_STRETCH_W-1:0] stretch_len
);

  rxdp_reg_addr_e          addr;
  logic                    acc;
  logic                    wr;
  logic                    addr_ok;
  logic [`RXDP_CNT_W-1:0]  drop_cnt;

  assign addr    = rxdp_reg_addr_e'(paddr);
  assign acc     = psel & penable;   // Access phase
  assign wr      = acc & pwrite;
  assign pready  = 1'b1;             // No wait states
  assign pslverr = acc & ~addr_ok;

  // --------------------------------------------------
  // Read mux and address decode
  // --------------------------------------------------
  always_comb begin
    addr_ok = 1'b1;
    prdata  = '0;
    case (addr)
      REG_CTRL:    prdata[3:0] = {stop_read, wm_en, map_mode};
      REG_STRETCH: prdata[`RXDP_STRETCH_W-1:0] = stretch_len;
      REG_DROP:    prdata[`RXDP_CNT_W-1:0] = drop_cnt;
      REG_LEVEL:   prdata[`RXDP_FIFO_AW:0] = level;
      default:     addr_ok = 1'b0;   // Hole in the map
    endcase
  end

  always_ff @(posedge rx_clock_fifo_clk or negedge arst_n) begin
    if (!arst_n) begin
      map_mode    <= MAP_EHIP;
      wm_en       <= 1'b0;
      stop_read   <= 1'b0;
      stretch_len <= '0;
    end else if (wr) begin
      case (addr)
        REG_CTRL: begin
          map_mode  <= rxdp_map_mode_e'(pwdata[1:0]);
          wm_en     <= pwdata[2];
          stop_read <= pwdata[3];
        end
        REG_STRETCH: stretch_len <= pwdata[`RXDP_STRETCH_W-1:0];
        default: ;
      endcase
    end
  end

  // Overflow count, any write clears it
  always_ff @(posedge rx_clock_fifo_clk or negedge arst_n) begin
    if (!arst_n)
      drop_cnt <= '0;
    else if (wr && addr == REG_DROP)
      drop_cnt <= '0;
    else if (drop && drop_cnt != '1)
      drop_cnt <= drop_cnt + 1'b1;
  end

  // Bus master keeps psel up for the whole transfer
  a_penable_psel: assert property (@(posedge rx_clock_fifo_clk) disable iff (!arst_n)
    penable |-> psel);

endmodule

`default_nettype wire

//--- src/rxdp_map.sv
`default_nettype none
`timescale 1ns/1ps

`include "rxdp_config.svh"

module rxdp_map
  import rxdp_pkg::*;
(
  input  logic                     rx_clock_fifo_clk,
  input  logic                     arst_n,
  input  logic                     in_valid,
  input  logic [`RXDP_SRC_W-1:0]   ehip_data,
  input  logic [`RXDP_SRC_W-1:0]   elane_data,
  input  logic [`RXDP_SRC_W-1:0]   rsfec_data,
  input  logic [`RXDP_WORD_W-1:0]  tx_fifo_data_lpbk,
  input  rxdp_map_mode_e           map_mode,
  input  logic                     wm_en,
  output logic                     push,
  output logic [`RXDP_WORD_W-1:0]  push_data
);

  logic [`RXDP_SRC_W-1:0]   lane_data;
  logic [`RXDP_WORD_W-1:0]  raw_word;
  logic [`RXDP_WORD_W-1:0]  mark_word;

  always_comb begin
    case (map_mode)
      MAP_ELANE: lane_data = elane_data;
      MAP_RSFEC: lane_data = rsfec_data;
      MAP_EHIP:  lane_data = ehip_data;
      default:   lane_data = ehip_data;   // Unused in loopback
    endcase
  end

  // Lane word split in two, each half gets a marker slot on top
  assign raw_word = (map_mode == MAP_LPBK) ? tx_fifo_data_lpbk :
                    {1'b0, lane_data[`RXDP_SRC_W-1:`RXDP_SRC_W/2],
                     1'b0, lane_data[`RXDP_SRC_W/2-1:0]};

  // Word mark forces 1 on the upper slot, 0 on the lower
  assign mark_word = wm_en ?
                     {1'b1, raw_word[`RXDP_WORD_W-2:`RXDP_HALF_W],
                      1'b0, raw_word[`RXDP_HALF_W-2:0]} :
                     raw_word;

  always_ff @(posedge rx_clock_fifo_clk or negedge arst_n) begin
    if (!arst_n)
      push <= 1'b0;
    else
      push <= in_valid;
  end

  always_ff @(posedge rx_clock_fifo_clk) begin
    if (in_valid)
      push_data <= mark_word;
  end

endmodule

`default_nettype wire

//--- src/rxdp_fifo.sv
`default_nettype none
`timescale 1ns/1ps

`include "rxdp_config.svh"

module rxdp_fifo (
  input  logic                     rx_clock_fifo_clk,
  input  logic                     arst_n,
  input  logic                     push,
  input  logic [`RXDP_WORD_W-1:0]  push_data,
  input  logic                     pop,
  output logic [`RXDP_WORD_W-1:0]  rd_data,
  output logic                     empty,
  output logic                     full,
  output logic                     drop,
  output logic [`RXDP_FIFO_AW:0]   level
);

  logic [`RXDP_WORD_W-1:0]  mem [`RXDP_FIFO_DEPTH];
  logic [`RXDP_FIFO_AW-1:0] wr_ptr;
  logic [`RXDP_FIFO_AW-1:0] rd_ptr;
  logic [`RXDP_FIFO_AW:0]   count;
  logic                     wr_en;
  logic                     rd_en;

  assign full    = (count == `RXDP_FIFO_DEPTH);
  assign empty   = (count == '0);
  assign wr_en   = push & ~full;
  assign rd_en   = pop & ~empty;
  assign drop    = push & full;   // Word lost, contents untouched
  assign level   = count;
  assign rd_data = mem[rd_ptr];   // Head entry, no read latency

  // --------------------------------------------------
  // Storage
  // --------------------------------------------------
  always_ff @(posedge rx_clock_fifo_clk) begin
    if (wr_en)
      mem[wr_ptr] <= push_data;
  end

  // --------------------------------------------------
  // Pointers and occupancy
  // --------------------------------------------------
  always_ff @(posedge rx_clock_fifo_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en)
        wr_ptr <= wr_ptr + 1'b1;   // Wraps at depth
      if (rd_en)
        rd_ptr <= rd_ptr + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  // Read side must never pull from an empty buffer
  a_no_pop_empty: assert property (@(posedge rx_clock_fifo_clk) disable iff (!arst_n)
    pop |-> !empty);

endmodule

`default_nettype wire

//--- src/rxdp_rd_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

`include "rxdp_config.svh"

module rxdp_rd_ctrl
  import rxdp_pkg::*;
(
  input  logic                       rx_clock_fifo_clk,
  input  logic                       arst_n,
  input  logic [`RXDP_WORD_W-1:0]    rd_data,
  input  logic                       empty,
  input  logic                       full,
  input  logic                       stop_read,
  input  logic [`RXDP_STRETCH_W-1:0] stretch_len,
  output logic                       pop,
  output logic [`RXDP_HALF_W-1:0]    data_out,
  output logic                       data_valid,
  output logic                       fifo_empty_flag,
  output logic                       fifo_full_flag
);

  rxdp_rd_state_e           state;
  rxdp_rd_state_e           state_nxt;
  logic [`RXDP_WORD_W-1:0]  hold;
  logic [7:0]               empty_hist;
  logic [7:0]               full_hist;
  logic [7:0]               hist_mask;

  // --------------------------------------------------
  // Word FSM, one pop per two output cycles
  // --------------------------------------------------
  assign pop = ~empty & ~stop_read & (state == RD_IDLE || state == RD_HI);

  always_comb begin
    state_nxt = state;
    case (state)
      RD_IDLE: if (pop) state_nxt = RD_LO;
      RD_LO:   state_nxt = RD_HI;
      RD_HI:   state_nxt = pop ? RD_LO : RD_IDLE;   // Back to back if data waits
      default: state_nxt = RD_IDLE;
    endcase
  end

  always_ff @(posedge rx_clock_fifo_clk or negedge arst_n) begin
    if (!arst_n)
      state <= RD_IDLE;
    else
      state <= state_nxt;
  end

  always_ff @(posedge rx_clock_fifo_clk) begin
    if (pop)
      hold <= rd_data;
  end

  assign data_valid = (state == RD_LO) || (state == RD_HI);
  assign data_out   = (state == RD_HI) ? hold[`RXDP_WORD_W-1:`RXDP_HALF_W]
                                       : hold[`RXDP_HALF_W-1:0];   // Low half first

  // --------------------------------------------------
  // Flag stretch
  // --------------------------------------------------
  // Bit k of a history is the raw flag k+1 cycles back
  assign hist_mask = (8'd1 << stretch_len) - 8'd1;

  always_ff @(posedge rx_clock_fifo_clk or negedge arst_n) begin
    if (!arst_n) begin
      empty_hist <= 8'hFF;   // Buffer starts out empty
      full_hist  <= 8'h00;
    end else begin
      empty_hist <= {empty_hist[6:0], empty};
      full_hist  <= {full_hist[6:0], full};
    end
  end

  assign fifo_empty_flag = empty | (|(empty_hist & hist_mask));
  assign fifo_full_flag  = full | (|(full_hist & hist_mask));

endmodule

`default_nettype wire

//--- src/rxdp_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "rxdp_config.svh"

module rxdp_top
  import rxdp_pkg::*;
(
  input  logic                     rx_clock_fifo_clk,
  input  logic                     arst_n,
  // APB slave
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  logic [`RXDP_APB_AW-1:0]  paddr,
  input  logic [31:0]              pwdata,
  output logic [31:0]              prdata,
  output logic                     pready,
  output logic                     pslverr,
  // Lane and loopback sources
  input  logic                     in_valid,
  input  logic [`RXDP_SRC_W-1:0]   ehip_data,
  input  logic [`RXDP_SRC_W-1:0]   elane_data,
  input  logic [`RXDP_SRC_W-1:0]   rsfec_data,
  input  logic [`RXDP_WORD_W-1:0]  tx_fifo_data_lpbk,
  // Die-to-die side
  output logic [`RXDP_HALF_W-1:0]  data_out,
  output logic                     data_valid,
  output logic                     fifo_empty_flag,
  output logic                     fifo_full_flag
);

  rxdp_map_mode_e              map_mode;
  logic                        wm_en;
  logic                        stop_read;
  logic [`RXDP_STRETCH_W-1:0]  stretch_len;
  logic                        push;
  logic [`RXDP_WORD_W-1:0]     push_data;
  logic                        pop;
  logic [`RXDP_WORD_W-1:0]     rd_data;
  logic                        empty;
  logic                        full;
  logic                        drop;
  logic [`RXDP_FIFO_AW:0]      level;

  rxdp_csr u_csr (
    .rx_clock_fifo_clk (rx_clock_fifo_clk), .arst_n (arst_n),
    .psel (psel), .penable (penable), .pwrite (pwrite), .paddr (paddr),
    .pwdata (pwdata), .drop (drop), .level (level), .prdata (prdata),
    .pready (pready), .pslverr (pslverr), .map_mode (map_mode), .wm_en (wm_en),
    .stop_read (stop_read), .stretch_len (stretch_len)
  );

  rxdp_map u_map (
    .rx_clock_fifo_clk (rx_clock_fifo_clk), .arst_n (arst_n), .in_valid (in_valid),
    .ehip_data (ehip_data), .elane_data (elane_data), .rsfec_data (rsfec_data),
    .tx_fifo_data_lpbk (tx_fifo_data_lpbk), .map_mode (map_mode), .wm_en (wm_en),
    .push (push), .push_data (push_data)
  );

  rxdp_fifo u_fifo (
    .rx_clock_fifo_clk (rx_clock_fifo_clk), .arst_n (arst_n), .push (push),
    .push_data (push_data), .pop (pop), .rd_data (rd_data), .empty (empty),
    .full (full), .drop (drop), .level (level)
  );

  rxdp_rd_ctrl u_rd_ctrl (
    .rx_clock_fifo_clk (rx_clock_fifo_clk), .arst_n (arst_n), .rd_data (rd_data),
    .empty (empty), .full (full), .stop_read (stop_read), .stretch_len (stretch_len),
    .pop (pop), .data_out (data_out), .data_valid (data_valid),
    .fifo_empty_flag (fifo_empty_flag), .fifo_full_flag (fifo_full_flag)
  );

endmodule

`default_nettype wire

//--- tests/rxdp_clk_gen.sv
`default_nettype none
`timescale 1ns/1ps

module rxdp_clk_gen (
  output logic clk,
  output logic arst_n
);

  localparam int HALF_PERIOD_NS = 10;   // 20 ns clock
  localparam int RESET_CYCLES   = 5;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD_NS) clk = ~clk;
  end

  // Release lands on a rising edge
  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
  end

endmodule

`default_nettype wire

//--- tests/rxdp_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "rxdp_config.svh"

module rxdp_tb
  import rxdp_pkg::*;
();

  localparam int WORDS_PER_MODE = 40;
  localparam int OVF_WORDS      = 20;
  localparam int STRETCH_LEN    = 3;
  // Six cycles per word plus a margin for APB traffic and drains
  localparam int TIMEOUT_CYCLES = (8 * WORDS_PER_MODE + OVF_WORDS + 1) * 6 + 500;

  logic                      clk;
  logic                      arst_n;
  logic                      psel;
  logic                      penable;
  logic                      pwrite;
  logic [`RXDP_APB_AW-1:0]   paddr;
  logic [31:0]               pwdata;
  logic [31:0]               prdata;
  logic                      pready;
  logic                      pslverr;
  logic                      in_valid;
  logic [`RXDP_SRC_W-1:0]    ehip_data;
  logic [`RXDP_SRC_W-1:0]    elane_data;
  logic [`RXDP_SRC_W-1:0]    rsfec_data;
  logic [`RXDP_WORD_W-1:0]   tx_fifo_data_lpbk;
  logic [`RXDP_HALF_W-1:0]   data_out;
  logic                      data_valid;
  logic                      fifo_empty_flag;
  logic                      fifo_full_flag;

  logic [`RXDP_HALF_W-1:0]   exp_q[$];   // Expected halves in output order
  logic [`RXDP_HALF_W-1:0]   exp_half;
  string                     test_name;
  int unsigned               cycles = 0;
  rxdp_map_mode_e            cur_mode;
  logic                      cur_wm;

  rxdp_clk_gen u_clk_gen (.clk (clk), .arst_n (arst_n));

  rxdp_top u_dut (
    .rx_clock_fifo_clk (clk), .arst_n (arst_n),
    .psel (psel), .penable (penable), .pwrite (pwrite), .paddr (paddr),
    .pwdata (pwdata), .prdata (prdata), .pready (pready), .pslverr (pslverr),
    .in_valid (in_valid), .ehip_data (ehip_data), .elane_data (elane_data),
    .rsfec_data (rsfec_data), .tx_fifo_data_lpbk (tx_fifo_data_lpbk),
    .data_out (data_out), .data_valid (data_valid),
    .fifo_empty_flag (fifo_empty_flag), .fifo_full_flag (fifo_full_flag)
  );

  // --------------------------------------------------
  // Reference model and helpers
  // --------------------------------------------------
  function automatic logic [`RXDP_WORD_W-1:0] expected_word(
    input rxdp_map_mode_e mode, input logic wm, input logic [`RXDP_SRC_W-1:0] e,
    input logic [`RXDP_SRC_W-1:0] l, input logic [`RXDP_SRC_W-1:0] r,
    input logic [`RXDP_WORD_W-1:0] lp);
    logic [`RXDP_SRC_W-1:0]  src;
    logic [`RXDP_WORD_W-1:0] w;
    case (mode)
      MAP_ELANE: src = l;
      MAP_RSFEC: src = r;
      default:   src = e;
    endcase
    if (mode == MAP_LPBK)
      w = lp;
    else
      w = {1'b0, src[77:39], 1'b0, src[38:0]};   // Marker slot above each half
    if (wm) begin
      w[79] = 1'b1;
      w[39] = 1'b0;
    end
    return w;
  endfunction

  function automatic logic [`RXDP_SRC_W-1:0] rand_lane();
    logic [95:0] r;
    r = {$urandom, $urandom, $urandom};
    return r[`RXDP_SRC_W-1:0];
  endfunction

  function automatic logic [`RXDP_WORD_W-1:0] rand_word();
    logic [95:0] r;
    r = {$urandom, $urandom, $urandom};
    return r[`RXDP_WORD_W-1:0];
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check_value(input string what, input logic [79:0] exp,
                             input logic [79:0] act);
    assert (act == exp) else
      fail_run($sformatf("[ERROR] %s: %s expected 0x%0h, actual 0x%0h",
                         test_name, what, exp, act));
  endtask

  // --------------------------------------------------
  // APB master
  // --------------------------------------------------
  task automatic apb_write(input logic [`RXDP_APB_AW-1:0] addr, input logic [31:0] data,
                           output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    err = pslverr;
    check_value("write pready", 1'b1, pready);
    @(posedge clk);   // Register updates here
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input logic [`RXDP_APB_AW-1:0] addr, output logic [31:0] data,
                          output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);   // Access phase with prdata settled
    data = prdata;
    err  = pslverr;
    check_value("read pready", 1'b1, pready);
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic write_reg(input logic [`RXDP_APB_AW-1:0] addr, input logic [31:0] data);
    logic err;
    apb_write(addr, data, err);
    check_value("write pslverr", 1'b0, err);
  endtask

  task automatic read_check(input logic [`RXDP_APB_AW-1:0] addr, input logic [31:0] exp,
                            input string what);
    logic [31:0] data;
    logic        err;
    apb_read(addr, data, err);
    check_value(what, exp, data);
    check_value({what, " pslverr"}, 1'b0, err);
  endtask

  task automatic set_ctrl(input rxdp_map_mode_e mode, input logic wm, input logic stop);
    cur_mode = mode;
    cur_wm   = wm;
    write_reg(REG_CTRL, {28'd0, stop, wm, mode});
  endtask

  // --------------------------------------------------
  // Word source
  // --------------------------------------------------
  task automatic send_word(input logic keep, input int gap);
    logic [`RXDP_SRC_W-1:0]  e;
    logic [`RXDP_SRC_W-1:0]  l;
    logic [`RXDP_SRC_W-1:0]  r;
    logic [`RXDP_WORD_W-1:0] lp;
    logic [`RXDP_WORD_W-1:0] w;
    e  = rand_lane();
    l  = rand_lane();
    r  = rand_lane();
    lp = rand_word();
    w  = expected_word(cur_mode, cur_wm, e, l, r, lp);
    @(posedge clk);
    ehip_data         <= e;
    elane_data        <= l;
    rsfec_data        <= r;
    tx_fifo_data_lpbk <= lp;
    in_valid          <= 1'b1;
    if (keep) begin   // Dropped words never come out
      exp_q.push_back(w[`RXDP_HALF_W-1:0]);
      exp_q.push_back(w[`RXDP_WORD_W-1:`RXDP_HALF_W]);
    end
    @(posedge clk);
    in_valid <= 1'b0;
    repeat (gap) @(posedge clk);
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0)
      @(posedge clk);
    repeat (2) @(posedge clk);
  endtask

  // --------------------------------------------------
  // Comparator and watchdog
  // --------------------------------------------------
  always @(negedge clk) begin
    if (arst_n && data_valid) begin
      assert (exp_q.size() != 0) else
        fail_run($sformatf("Output half 0x%0h came out with no word pending in test %s",
                           data_out, test_name));
      exp_half = exp_q.pop_front();
      check_value("data_out", exp_half, data_out);
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
      fail_run($sformatf("Timeout after %0d cycles in test %s", cycles, test_name));
  end

  initial begin : stimulus
    logic [31:0] rd;
    logic        err;
    int          held;
    psel              <= 1'b0;
    penable           <= 1'b0;
    pwrite            <= 1'b0;
    paddr             <= '0;
    pwdata            <= '0;
    in_valid          <= 1'b0;
    ehip_data         <= '0;
    elane_data        <= '0;
    rsfec_data        <= '0;
    tx_fifo_data_lpbk <= '0;
    cur_mode = MAP_EHIP;
    cur_wm   = 1'b0;
    void'($urandom(32'h8f418501));
    test_name = "reset";
    wait (arst_n === 1'b1);
    @(negedge clk);
    check_value("fifo_empty_flag", 1'b1, fifo_empty_flag);
    check_value("fifo_full_flag", 1'b0, fifo_full_flag);
    check_value("data_valid", 1'b0, data_valid);
    read_check(REG_CTRL, 32'h0, "REG_CTRL");
    read_check(REG_DROP, 32'h0, "REG_DROP");

    // All four sources with word mark off and on
    for (int m = 0; m < 4; m++) begin
      for (int w = 0; w < 2; w++) begin
        set_ctrl(rxdp_map_mode_e'(m[1:0]), w[0], 1'b0);
        test_name = $sformatf("map_%s_wm%0d", cur_mode.name(), w);
        repeat (WORDS_PER_MODE)
          send_word(1'b1, $urandom_range(2, 0));
        wait_drain();
      end
    end

    test_name = "overflow";
    write_reg(REG_STRETCH, STRETCH_LEN);
    set_ctrl(MAP_RSFEC, 1'b1, 1'b1);
    for (int i = 0; i < OVF_WORDS; i++)
      send_word(i < `RXDP_FIFO_DEPTH, 1);
    repeat (2) @(posedge clk);
    read_check(REG_LEVEL, `RXDP_FIFO_DEPTH, "REG_LEVEL");
    read_check(REG_DROP, OVF_WORDS - `RXDP_FIFO_DEPTH, "REG_DROP");
    @(negedge clk);
    check_value("fifo_full_flag", 1'b1, fifo_full_flag);
    check_value("halves held back", 2 * `RXDP_FIFO_DEPTH, exp_q.size());

    // Raw full drops with the first pop and the flag lingers for the stretch length
    set_ctrl(MAP_RSFEC, 1'b1, 1'b0);
    @(negedge clk);
    while (data_valid !== 1'b1)
      @(negedge clk);
    held = 0;
    while (fifo_full_flag === 1'b1 && held <= 8) begin
      held++;
      @(negedge clk);
    end
    check_value("full flag hold cycles", STRETCH_LEN, held);
    wait_drain();

    test_name = "drop_clear";
    read_check(REG_DROP, OVF_WORDS - `RXDP_FIFO_DEPTH, "REG_DROP");
    write_reg(REG_DROP, 32'hFF);
    read_check(REG_DROP, 32'h0, "REG_DROP");

    test_name = "apb_error";
    apb_read(4'h2, rd, err);
    check_value("read pslverr", 1'b1, err);
    apb_write(4'h2, 32'hFFFF_FFFF, err);
    check_value("write pslverr", 1'b1, err);
    read_check(REG_CTRL, {28'd0, 1'b0, cur_wm, cur_mode}, "REG_CTRL");
    read_check(REG_STRETCH, STRETCH_LEN, "REG_STRETCH");

    // Raw empty dips for a single cycle as one word passes an idle FIFO
    test_name = "empty_stretch";
    send_word(1'b1, 0);
    repeat (8) begin
      @(negedge clk);
      check_value("fifo_empty_flag", 1'b1, fifo_empty_flag);
    end
    wait_drain();

    repeat (5) @(posedge clk);
    if (exp_q.size() == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      fail_run($sformatf("%0d expected output halves never came out", exp_q.size()));
    end
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+src
src/rxdp_pkg.sv
src/rxdp_csr.sv
src/rxdp_map.sv
src/rxdp_fifo.sv
src/rxdp_rd_ctrl.sv
src/rxdp_top.sv
tests/rxdp_clk_gen.sv
tests/rxdp_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = rxdp_tb
FLIST     = vlog.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SRCS      = $(wildcard src/*.sv src/*.svh tests/*.sv)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
